// ==== source/rv_isa_pkg.sv ====
////////////////////////////////////////
// RV32IM instruction definitions
////////////////////////////////////////

package rv_isa_pkg;

  localparam int ILEN      = 32;
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int OP_W      = 6;
  localparam int IMM_FMT_W = 3;

  typedef logic [ILEN-1:0]      instr_t;
  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // major opcodes, bits 6:0
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // zero is reserved for illegal words
  typedef enum logic [OP_W-1:0] {
    OP_ILLEGAL = 6'd0,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_FENCE, OP_ECALL, OP_EBREAK,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU
  } rv_op_e;

  typedef enum logic [IMM_FMT_W-1:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

endpackage

// ==== source/decode_cfg_pkg.sv ====
////////////////////////////////////////
// decode stage buffer and credits
////////////////////////////////////////

package decode_cfg_pkg;

  localparam int BUF_DEPTH   = 4;
  localparam int OUT_CREDITS = 2;

  localparam int BUF_IDX_W = $clog2(BUF_DEPTH);
  localparam int CREDIT_W  = $clog2(OUT_CREDITS + 1);

  typedef logic [BUF_IDX_W-1:0] buf_idx_t;
  // one extra bit so a full buffer is representable
  typedef logic [BUF_IDX_W:0]   buf_cnt_t;
  typedef logic [CREDIT_W-1:0]  credit_cnt_t;

endpackage

// ==== source/instr_buffer.sv ====
////////////////////////////////////////
// instruction word buffer
////////////////////////////////////////

`timescale 1ns/1ps

module instr_buffer (
  input  logic                     clk_i,
  input  logic                     wr_en_i,
  input  decode_cfg_pkg::buf_idx_t wr_idx_i,
  input  rv_isa_pkg::instr_t       wr_data_i,
  input  decode_cfg_pkg::buf_idx_t rd_idx_i,
  output rv_isa_pkg::instr_t       rd_data_o
);

  import rv_isa_pkg::*;
  import decode_cfg_pkg::*;

  instr_t mem_q [BUF_DEPTH];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx_i] <= wr_data_i;
    end
  end

  // head entry seen without a clock
  assign rd_data_o = mem_q[rd_idx_i];

endmodule

// ==== source/instr_classify.sv ====
////////////////////////////////////////
// operation and register classify
////////////////////////////////////////

`timescale 1ns/1ps

module instr_classify (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  rv_isa_pkg::instr_t   instr_i,
  input  logic                 issue_i,
  output rv_isa_pkg::imm_fmt_e imm_fmt_o,
  output rv_isa_pkg::rv_op_e   op_o,
  output rv_isa_pkg::reg_idx_t rd_o,
  output rv_isa_pkg::reg_idx_t rs1_o,
  output rv_isa_pkg::reg_idx_t rs2_o
);

  import rv_isa_pkg::*;

  rv_op_e     op_d;
  imm_fmt_e   fmt;
  // rd, rs1, rs2
  logic [2:0] use_regs;

  ////////////////////////////////////////
  // mask and match table
  ////////////////////////////////////////

  always_comb begin
    op_d = OP_ILLEGAL;
    if ((instr_i & 32'h0000007F) == 32'h00000037) op_d = OP_LUI;
    if ((instr_i & 32'h0000007F) == 32'h00000017) op_d = OP_AUIPC;
    if ((instr_i & 32'h0000007F) == 32'h0000006F) op_d = OP_JAL;
    if ((instr_i & 32'h0000707F) == 32'h00000067) op_d = OP_JALR;
    if ((instr_i & 32'h0000707F) == 32'h00000063) op_d = OP_BEQ;
    if ((instr_i & 32'h0000707F) == 32'h00001063) op_d = OP_BNE;
    if ((instr_i & 32'h0000707F) == 32'h00004063) op_d = OP_BLT;
    if ((instr_i & 32'h0000707F) == 32'h00005063) op_d = OP_BGE;
    if ((instr_i & 32'h0000707F) == 32'h00006063) op_d = OP_BLTU;
    if ((instr_i & 32'h0000707F) == 32'h00007063) op_d = OP_BGEU;
    if ((instr_i & 32'h0000707F) == 32'h00000003) op_d = OP_LB;
    if ((instr_i & 32'h0000707F) == 32'h00001003) op_d = OP_LH;
    if ((instr_i & 32'h0000707F) == 32'h00002003) op_d = OP_LW;
    if ((instr_i & 32'h0000707F) == 32'h00004003) op_d = OP_LBU;
    if ((instr_i & 32'h0000707F) == 32'h00005003) op_d = OP_LHU;
    if ((instr_i & 32'h0000707F) == 32'h00000023) op_d = OP_SB;
    if ((instr_i & 32'h0000707F) == 32'h00001023) op_d = OP_SH;
    if ((instr_i & 32'h0000707F) == 32'h00002023) op_d = OP_SW;
    if ((instr_i & 32'h0000707F) == 32'h00000013) op_d = OP_ADDI;
    if ((instr_i & 32'h0000707F) == 32'h00002013) op_d = OP_SLTI;
    if ((instr_i & 32'h0000707F) == 32'h00003013) op_d = OP_SLTIU;
    if ((instr_i & 32'h0000707F) == 32'h00004013) op_d = OP_XORI;
    if ((instr_i & 32'h0000707F) == 32'h00006013) op_d = OP_ORI;
    if ((instr_i & 32'h0000707F) == 32'h00007013) op_d = OP_ANDI;
    if ((instr_i & 32'hFE00707F) == 32'h00001013) op_d = OP_SLLI;
    if ((instr_i & 32'hFE00707F) == 32'h00005013) op_d = OP_SRLI;
    if ((instr_i & 32'hFE00707F) == 32'h40005013) op_d = OP_SRAI;
    if ((instr_i & 32'hFE00707F) == 32'h00000033) op_d = OP_ADD;
    if ((instr_i & 32'hFE00707F) == 32'h40000033) op_d = OP_SUB;
    if ((instr_i & 32'hFE00707F) == 32'h00001033) op_d = OP_SLL;
    if ((instr_i & 32'hFE00707F) == 32'h00002033) op_d = OP_SLT;
    if ((instr_i & 32'hFE00707F) == 32'h00003033) op_d = OP_SLTU;
    if ((instr_i & 32'hFE00707F) == 32'h00004033) op_d = OP_XOR;
    if ((instr_i & 32'hFE00707F) == 32'h00005033) op_d = OP_SRL;
    if ((instr_i & 32'hFE00707F) == 32'h40005033) op_d = OP_SRA;
    if ((instr_i & 32'hFE00707F) == 32'h00006033) op_d = OP_OR;
    if ((instr_i & 32'hFE00707F) == 32'h00007033) op_d = OP_AND;
    if ((instr_i & 32'h0000707F) == 32'h0000000F) op_d = OP_FENCE;
    if ((instr_i & 32'hFFFFFFFF) == 32'h00000073) op_d = OP_ECALL;
    if ((instr_i & 32'hFFFFFFFF) == 32'h00100073) op_d = OP_EBREAK;
    if ((instr_i & 32'hFE00707F) == 32'h02000033) op_d = OP_MUL;
    if ((instr_i & 32'hFE00707F) == 32'h02001033) op_d = OP_MULH;
    if ((instr_i & 32'hFE00707F) == 32'h02002033) op_d = OP_MULHSU;
    if ((instr_i & 32'hFE00707F) == 32'h02003033) op_d = OP_MULHU;
    if ((instr_i & 32'hFE00707F) == 32'h02004033) op_d = OP_DIV;
    if ((instr_i & 32'hFE00707F) == 32'h02005033) op_d = OP_DIVU;
    if ((instr_i & 32'hFE00707F) == 32'h02006033) op_d = OP_REM;
    if ((instr_i & 32'hFE00707F) == 32'h02007033) op_d = OP_REMU;
  end

  // format and register use follow the major opcode of a legal word
  always_comb begin
    fmt      = IMM_NONE;
    use_regs = 3'b000;
    if (op_d != OP_ILLEGAL) begin
      case (instr_i[6:0])
        OPC_LUI, OPC_AUIPC:               fmt = IMM_U;
        OPC_JAL:                          fmt = IMM_J;
        OPC_JALR, OPC_LOAD, OPC_OP_IMM:   fmt = IMM_I;
        OPC_STORE:                        fmt = IMM_S;
        OPC_BRANCH:                       fmt = IMM_B;
        default:                          fmt = IMM_NONE;
      endcase
      case (instr_i[6:0])
        OPC_OP:                           use_regs = 3'b111;
        OPC_JALR, OPC_LOAD, OPC_OP_IMM:   use_regs = 3'b110;
        OPC_STORE, OPC_BRANCH:            use_regs = 3'b011;
        OPC_LUI, OPC_AUIPC, OPC_JAL:      use_regs = 3'b100;
        OPC_MISC_MEM, OPC_SYSTEM:         use_regs = 3'b000;
        default:                          use_regs = 3'b000;
      endcase
    end
  end

  assign imm_fmt_o = fmt;

  ////////////////////////////////////////
  // result registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_o  <= OP_ILLEGAL;
      rd_o  <= '0;
      rs1_o <= '0;
      rs2_o <= '0;
    end else if (issue_i) begin
      op_o  <= op_d;
      rd_o  <= use_regs[2] ? instr_i[11:7] : '0;
      rs1_o <= use_regs[1] ? instr_i[19:15] : '0;
      rs2_o <= use_regs[0] ? instr_i[24:20] : '0;
    end
  end

endmodule

// ==== source/imm_gen.sv ====
////////////////////////////////////////
// immediate generation
////////////////////////////////////////

`timescale 1ns/1ps

module imm_gen (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  rv_isa_pkg::instr_t   instr_i,
  input  rv_isa_pkg::imm_fmt_e imm_fmt_i,
  input  logic                 issue_i,
  output rv_isa_pkg::xlen_t    imm_o
);

  import rv_isa_pkg::*;

  xlen_t imm_d;

  // sign always comes from bit 31
  always_comb begin
    case (imm_fmt_i)
      IMM_I:   imm_d = {{20{instr_i[31]}}, instr_i[31:20]};
      IMM_S:   imm_d = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      IMM_B:   imm_d = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
      IMM_U:   imm_d = {instr_i[31:12], 12'h000};
      IMM_J:   imm_d = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
      default: imm_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      imm_o <= '0;
    end else if (issue_i) begin
      imm_o <= imm_d;
    end
  end

endmodule

// ==== source/decode_flow_ctrl.sv ====
////////////////////////////////////////
// buffer and credit control
////////////////////////////////////////

`timescale 1ns/1ps

module decode_flow_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     instr_valid_i,
  input  logic                     dec_credit_i,
  output logic                     wr_en_o,
  output decode_cfg_pkg::buf_idx_t wr_idx_o,
  output decode_cfg_pkg::buf_idx_t rd_idx_o,
  output logic                     issue_o,
  output logic                     dec_valid_o,
  output logic                     instr_credit_o
);

  import decode_cfg_pkg::*;

  typedef enum logic {
    FLOW_IDLE,
    FLOW_ACTIVE
  } flow_state_e;

  flow_state_e state_q, state_d;
  buf_idx_t    wr_ptr_q, rd_ptr_q;
  buf_cnt_t    count_q, count_d;
  credit_cnt_t credit_q, credit_d;

  // upstream credits keep the buffer from overflowing
  assign wr_en_o  = instr_valid_i;
  assign wr_idx_o = wr_ptr_q;
  assign rd_idx_o = rd_ptr_q;
  assign issue_o  = (state_q == FLOW_ACTIVE) && (credit_q != '0);

  assign count_d  = count_q + buf_cnt_t'(instr_valid_i) - buf_cnt_t'(issue_o);
  // return and spend in one cycle cancel out
  assign credit_d = credit_q - credit_cnt_t'(issue_o) + credit_cnt_t'(dec_credit_i);
  assign state_d  = (count_d != '0) ? FLOW_ACTIVE : FLOW_IDLE;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q        <= FLOW_IDLE;
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      count_q        <= '0;
      credit_q       <= credit_cnt_t'(OUT_CREDITS);
      dec_valid_o    <= 1'b0;
      instr_credit_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      wr_ptr_q       <= wr_ptr_q + buf_idx_t'(instr_valid_i);
      rd_ptr_q       <= rd_ptr_q + buf_idx_t'(issue_o);
      count_q        <= count_d;
      credit_q       <= credit_d;
      dec_valid_o    <= issue_o;
      instr_credit_o <= issue_o;
    end
  end

endmodule

// ==== source/rv_decode_top.sv ====
////////////////////////////////////////
// RV32IM decode stage
////////////////////////////////////////

`timescale 1ns/1ps

module rv_decode_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 instr_valid_i,
  input  rv_isa_pkg::instr_t   instr_i,
  output logic                 instr_credit_o,
  input  logic                 dec_credit_i,
  output logic                 dec_valid_o,
  output rv_isa_pkg::rv_op_e   dec_op_o,
  output rv_isa_pkg::reg_idx_t dec_rd_o,
  output rv_isa_pkg::reg_idx_t dec_rs1_o,
  output rv_isa_pkg::reg_idx_t dec_rs2_o,
  output rv_isa_pkg::xlen_t    dec_imm_o
);

  import rv_isa_pkg::*;
  import decode_cfg_pkg::*;

  logic     wr_en;
  logic     issue;
  buf_idx_t wr_idx;
  buf_idx_t rd_idx;
  instr_t   head_instr;
  imm_fmt_e imm_fmt;

  decode_flow_ctrl i_flow_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .dec_credit_i   (dec_credit_i),
    .wr_en_o        (wr_en),
    .wr_idx_o       (wr_idx),
    .rd_idx_o       (rd_idx),
    .issue_o        (issue),
    .dec_valid_o    (dec_valid_o),
    .instr_credit_o (instr_credit_o)
  );

  instr_buffer i_buffer (
    .clk_i     (clk_i),
    .wr_en_i   (wr_en),
    .wr_idx_i  (wr_idx),
    .wr_data_i (instr_i),
    .rd_idx_i  (rd_idx),
    .rd_data_o (head_instr)
  );

  instr_classify i_classify (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .instr_i   (head_instr),
    .issue_i   (issue),
    .imm_fmt_o (imm_fmt),
    .op_o      (dec_op_o),
    .rd_o      (dec_rd_o),
    .rs1_o     (dec_rs1_o),
    .rs2_o     (dec_rs2_o)
  );

  imm_gen i_imm_gen (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .instr_i   (head_instr),
    .imm_fmt_i (imm_fmt),
    .issue_i   (issue),
    .imm_o     (dec_imm_o)
  );

endmodule

// ==== tb/rv_decode_model.sv ====
////////////////////////////////////////
// reference decode model
////////////////////////////////////////

package rv_decode_model;

  import rv_isa_pkg::*;

  typedef struct packed {
    rv_op_e   op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;
  } dec_res_t;

  function automatic dec_res_t decode_ref(input instr_t w);
    dec_res_t   r;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [2:0] used;
    imm_fmt_e   fmt;
    f3   = w[14:12];
    f7   = w[31:25];
    r    = '0;
    fmt  = IMM_NONE;
    used = 3'b000;
    case (w[6:0])
      OPC_LUI:   begin r.op = OP_LUI;   fmt = IMM_U; end
      OPC_AUIPC: begin r.op = OP_AUIPC; fmt = IMM_U; end
      OPC_JAL:   begin r.op = OP_JAL;   fmt = IMM_J; end
      OPC_JALR:  begin
        fmt = IMM_I;
        if (f3 == 3'd0) r.op = OP_JALR;
      end
      OPC_BRANCH: begin
        fmt = IMM_B;
        case (f3)
          3'd0: r.op = OP_BEQ;
          3'd1: r.op = OP_BNE;
          3'd4: r.op = OP_BLT;
          3'd5: r.op = OP_BGE;
          3'd6: r.op = OP_BLTU;
          3'd7: r.op = OP_BGEU;
          default: r.op = OP_ILLEGAL;
        endcase
      end
      OPC_LOAD: begin
        fmt = IMM_I;
        case (f3)
          3'd0: r.op = OP_LB;
          3'd1: r.op = OP_LH;
          3'd2: r.op = OP_LW;
          3'd4: r.op = OP_LBU;
          3'd5: r.op = OP_LHU;
          default: r.op = OP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        fmt = IMM_S;
        case (f3)
          3'd0: r.op = OP_SB;
          3'd1: r.op = OP_SH;
          3'd2: r.op = OP_SW;
          default: r.op = OP_ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        fmt = IMM_I;
        case (f3)
          3'd0: r.op = OP_ADDI;
          3'd2: r.op = OP_SLTI;
          3'd3: r.op = OP_SLTIU;
          3'd4: r.op = OP_XORI;
          3'd6: r.op = OP_ORI;
          3'd7: r.op = OP_ANDI;
          3'd1: r.op = (f7 == 7'h00) ? OP_SLLI : OP_ILLEGAL;
          default: r.op = (f7 == 7'h00) ? OP_SRLI : (f7 == 7'h20) ? OP_SRAI : OP_ILLEGAL;
        endcase
      end
      OPC_OP: begin
        used = 3'b111;
        case ({f7, f3})
          10'h000: r.op = OP_ADD;
          10'h001: r.op = OP_SLL;
          10'h002: r.op = OP_SLT;
          10'h003: r.op = OP_SLTU;
          10'h004: r.op = OP_XOR;
          10'h005: r.op = OP_SRL;
          10'h006: r.op = OP_OR;
          10'h007: r.op = OP_AND;
          10'h100: r.op = OP_SUB;
          10'h105: r.op = OP_SRA;
          10'h008: r.op = OP_MUL;
          10'h009: r.op = OP_MULH;
          10'h00A: r.op = OP_MULHSU;
          10'h00B: r.op = OP_MULHU;
          10'h00C: r.op = OP_DIV;
          10'h00D: r.op = OP_DIVU;
          10'h00E: r.op = OP_REM;
          10'h00F: r.op = OP_REMU;
          default: r.op = OP_ILLEGAL;
        endcase
      end
      OPC_MISC_MEM: if (f3 == 3'd0) r.op = OP_FENCE;
      OPC_SYSTEM: begin
        if (w == 32'h00000073) r.op = OP_ECALL;
        if (w == 32'h00100073) r.op = OP_EBREAK;
      end
      default: r.op = OP_ILLEGAL;
    endcase
    if (r.op == OP_ILLEGAL) begin
      fmt  = IMM_NONE;
      used = 3'b000;
    end
    case (fmt)
      IMM_I: used = 3'b110;
      IMM_S, IMM_B: used = 3'b011;
      IMM_U, IMM_J: used = 3'b100;
      default: used = used;
    endcase
    r.rd  = used[2] ? w[11:7] : 5'd0;
    r.rs1 = used[1] ? w[19:15] : 5'd0;
    r.rs2 = used[0] ? w[24:20] : 5'd0;
    case (fmt)
      IMM_I: r.imm = xlen_t'($signed(w[31:20]));
      IMM_S: r.imm = xlen_t'($signed({w[31:25], w[11:7]}));
      IMM_B: r.imm = xlen_t'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      IMM_U: r.imm = {w[31:12], 12'h000};
      IMM_J: r.imm = xlen_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default: r.imm = '0;
    endcase
    return r;
  endfunction

endpackage

// ==== tb/rv_decode_chk.sv ====
////////////////////////////////////////
// flow control checker
////////////////////////////////////////

`timescale 1ns/1ps

module rv_decode_chk (
  input logic                     clk_i,
  input logic                     rst_i,
  input logic                     issue_i,
  input logic                     wr_en_i,
  input logic                     dec_credit_i,
  input logic                     dec_valid_i,
  input logic                     instr_credit_i,
  input decode_cfg_pkg::buf_cnt_t count_i
);

  import decode_cfg_pkg::*;

  int fail_cnt = 0;
  // results issued and not yet paid back by downstream
  int in_flight;
  // words accepted and not yet credited back upstream
  int held;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_flight <= 0;
      held      <= 0;
    end else begin
      in_flight <= in_flight + int'(issue_i) - int'(dec_credit_i);
      held      <= held + int'(wr_en_i) - int'(instr_credit_i);
    end
  end

  a_issue_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_i |-> in_flight < OUT_CREDITS)
    else begin
      $error("issue with zero credit");
      fail_cnt++;
    end

  a_write_full: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_en_i |-> count_i != buf_cnt_t'(BUF_DEPTH))
    else begin
      $error("write into full buffer");
      fail_cnt++;
    end

  // each valid cycle takes a word that was waiting
  a_valid_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    dec_valid_i |-> $past(count_i) != '0)
    else begin
      $error("valid without a waiting word");
      fail_cnt++;
    end

  // upstream credit only with the result of an accepted word
  a_credit_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_credit_i == dec_valid_i && (!instr_credit_i || held != 0))
    else begin
      $error("credit and valid differ");
      fail_cnt++;
    end

endmodule

bind decode_flow_ctrl rv_decode_chk i_chk (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .issue_i        (issue_o),
  .wr_en_i        (wr_en_o),
  .dec_credit_i   (dec_credit_i),
  .dec_valid_i    (dec_valid_o),
  .instr_credit_i (instr_credit_o),
  .count_i        (count_q)
);

// ==== tb/tb_rv_decode.sv ====
////////////////////////////////////////
// decode stage testbench
////////////////////////////////////////

`timescale 1ns/1ps

module tb_rv_decode;

  import rv_isa_pkg::*;
  import decode_cfg_pkg::*;
  import rv_decode_model::*;

  localparam int TIMEOUT_CYCLES = 4000;

  logic clk_i = 1'b0;
  logic rst_i = 1'b1;
  logic instr_valid_i = 1'b0;
  instr_t instr_i = '0;
  logic dec_credit_i = 1'b0;
  logic instr_credit_o, dec_valid_o;
  rv_op_e dec_op_o;
  reg_idx_t dec_rd_o, dec_rs1_o, dec_rs2_o;
  xlen_t dec_imm_o;

  int seed = 32'h6691c8f0;
  int credit_seed = 32'h6691c8f0;
  int cyc = 0;
  int sent_cnt = 0;
  int ret_cnt = 0;
  int res_cnt = 0;
  int pending = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int accept_edge = 0;
  bit hold_credits = 0;
  bit rand_credit = 0;
  bit check_lat = 0;
  bit lat_seen = 0;
  dec_res_t exp_q[$];
  instr_t base_q[$];
  instr_t legal_q[$];

  rv_decode_top i_dut (.*);

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, results still outstanding", cyc);
      $display("** FAIL **");
      $finish;
    end
  end

  // downstream consumer, returns one credit per result
  always @(posedge clk_i) begin
    if (!rst_i && !hold_credits && pending > 0 &&
        (!rand_credit || ($random(credit_seed) & 3) == 0)) begin
      dec_credit_i <= 1'b1;
      pending = pending - 1;
    end else begin
      dec_credit_i <= 1'b0;
    end
  end

  function automatic instr_t enc(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic int avail();
    return BUF_DEPTH - sent_cnt + ret_cnt;
  endfunction

  task automatic compare_result();
    dec_res_t e;
    e = exp_q.pop_front();
    checks++;
    assert (dec_op_o == e.op) else begin
      $display("Error dec_op_o: got %h, expected %h", dec_op_o, e.op);
      errors++;
    end
    assert (dec_rd_o == e.rd) else begin
      $display("Error dec_rd_o: got %h, expected %h", dec_rd_o, e.rd);
      errors++;
    end
    assert (dec_rs1_o == e.rs1) else begin
      $display("Error dec_rs1_o: got %h, expected %h", dec_rs1_o, e.rs1);
      errors++;
    end
    assert (dec_rs2_o == e.rs2) else begin
      $display("Error dec_rs2_o: got %h, expected %h", dec_rs2_o, e.rs2);
      errors++;
    end
    assert (dec_imm_o == e.imm) else begin
      $display("Error dec_imm_o: got %h, expected %h", dec_imm_o, e.imm);
      errors++;
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      assert (!dec_valid_o && !instr_credit_o) else begin
        $display("valid or credit output high during reset");
        errors++;
      end
    end else begin
      if (instr_valid_i) begin
        exp_q.push_back(decode_ref(instr_i));
        accept_edge = cyc + 1;
      end
      if (instr_credit_o) ret_cnt++;
      if (dec_valid_o) begin
        res_cnt++;
        pending++;
        if (exp_q.size() == 0) begin
          $display("result appeared with no word outstanding");
          errors++;
        end else begin
          compare_result();
        end
        if (check_lat) begin
          lat_seen = 1;
          assert (cyc - accept_edge == 1) else begin
            $display("Error latency: got %h, expected %h", cyc - accept_edge + 1, 2);
            errors++;
          end
        end
      end
    end
  end

  task automatic send_word(input instr_t w);
    @(posedge clk_i);
    while (avail() == 0) @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i <= w;
    sent_cnt++;
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || pending != 0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-14s done, errors so far %0d", name, errors);
  endtask

  initial begin
    int base;
    instr_t w;
    for (int i = 0; i < 8; i++) begin
      if (i != 2 && i != 3) base_q.push_back(enc(7'h7A, 5'd3, 5'd4, i[2:0], 5'd21, OPC_BRANCH));
      if (i < 6 && i != 3) base_q.push_back(enc(7'h40, 5'd9, 5'd2, i[2:0], 5'd7, OPC_LOAD));
      if (i < 3) base_q.push_back(enc(7'h7F, 5'd6, 5'd8, i[2:0], 5'd12, OPC_STORE));
      if (i != 1 && i != 5) base_q.push_back(enc(7'h7F, 5'd17, 5'd5, i[2:0], 5'd9, OPC_OP_IMM));
      base_q.push_back(enc(7'h00, 5'd11, 5'd13, i[2:0], 5'd15, OPC_OP));
    end
    base_q.push_back(32'hFFFFF2B7);
    base_q.push_back(32'h12345097);
    base_q.push_back(32'hFFDFF0EF);
    base_q.push_back(32'hFF8100E7);
    base_q.push_back(enc(7'h00, 5'd3, 5'd1, 3'd1, 5'd2, OPC_OP_IMM));
    base_q.push_back(enc(7'h00, 5'd3, 5'd1, 3'd5, 5'd2, OPC_OP_IMM));
    base_q.push_back(enc(7'h20, 5'd3, 5'd1, 3'd5, 5'd2, OPC_OP_IMM));
    base_q.push_back(enc(7'h20, 5'd3, 5'd1, 3'd0, 5'd2, OPC_OP));
    base_q.push_back(enc(7'h20, 5'd3, 5'd1, 3'd5, 5'd2, OPC_OP));
    base_q.push_back(enc(7'h0F, 5'h13, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM));
    base_q.push_back(32'h00000073);
    base_q.push_back(32'h00100073);
    legal_q = base_q;

    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    assert (res_cnt == 0) else begin
      $display("a result appeared before any word was sent");
      errors++;
    end
    end_test("reset");

    foreach (base_q[i]) send_word(base_q[i]);
    drain();
    end_test("rv32i");

    for (int i = 0; i < 8; i++) begin
      w = enc(7'h01, 5'd30, 5'd29, i[2:0], 5'd31, OPC_OP);
      legal_q.push_back(w);
      send_word(w);
    end
    send_word(enc(7'h00, 5'd2, 5'd1, 3'd2, 5'd3, 7'b0101111));
    send_word(enc(7'h7F, 5'd2, 5'd1, 3'd2, 5'd3, 7'b0000111));
    send_word(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0111011));
    send_word(enc(7'h30, 5'd0, 5'd1, 3'd1, 5'd3, OPC_SYSTEM));
    send_word(32'h00000000);
    drain();
    end_test("m_and_illegal");

    check_lat = 1;
    send_word(32'h00A00093);
    drain();
    check_lat = 0;
    assert (lat_seen) else begin
      $display("no result appeared in the latency test");
      errors++;
    end
    end_test("latency");

    hold_credits = 1;
    base = res_cnt;
    for (int i = 0; i < 6; i++) send_word(legal_q[i]);
    repeat (20) @(posedge clk_i);
    assert (res_cnt - base == OUT_CREDITS && avail() == 0) else begin
      $display("back-pressure did not stop the stage after its credits");
      errors++;
    end
    hold_credits = 0;
    drain();
    assert (ret_cnt == sent_cnt) else begin
      $display("Error instr_credit_o count: got %h, expected %h", ret_cnt, sent_cnt);
      errors++;
    end
    end_test("backpressure");

    rand_credit = 1;
    repeat (200) begin
      if ($random(seed) & 1)
        w = legal_q[($random(seed) & 32'h7FFF) % legal_q.size()] ^ ($random(seed) & 32'h000F8F80);
      else
        w = $random(seed);
      send_word(w);
    end
    drain();
    end_test("random");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, i_dut.i_flow_ctrl.i_chk.fail_cnt);
    if (errors == 0 && i_dut.i_flow_ctrl.i_chk.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/rv_isa_pkg.sv
source/decode_cfg_pkg.sv
source/instr_buffer.sv
source/instr_classify.sv
source/imm_gen.sv
source/decode_flow_ctrl.sv
source/rv_decode_top.sv
tb/rv_decode_model.sv
tb/rv_decode_chk.sv
tb/tb_rv_decode.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the decode stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_decode -f vlog.f \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
grep -qF "** PASS **" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
